// File: source/dcache_pkg.sv
package dcache_pkg;

    // ----------------------------------------
    // Bus and cache geometry
    // ----------------------------------------

    localparam int ADDR_WIDTH  = 32;
    localparam int DATA_WIDTH  = 32;
    localparam int STRB_WIDTH  = DATA_WIDTH / 8;
    localparam int WAYS_NUMBER = 2;
    localparam int SETS_NUMBER = 16;
    localparam int INDEX_SIZE  = 4;
    localparam int TAG_SIZE    = 4;
    localparam int STORE_DEPTH = 256;

    // Word address into the backing store, covers the whole 1 KiB window
    localparam int STORE_ADDR_SIZE = $clog2(STORE_DEPTH);

    // Byte address layout: [9:6] tag, [5:2] index, [1:0] byte offset
    localparam int INDEX_LSB = 2;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_SIZE;

    // First byte address past the cacheable window
    localparam logic [ADDR_WIDTH-1:0] WINDOW_LIMIT = 32'd1024;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------

    // Request handed from decode to the execute stage
    typedef struct packed {
        logic                       is_write;
        logic                       out_of_range;
        logic [TAG_SIZE-1:0]        tag;
        logic [INDEX_SIZE-1:0]      index;
        logic [STORE_ADDR_SIZE-1:0] word_addr;
        logic [DATA_WIDTH-1:0]      wdata;
        logic [STRB_WIDTH-1:0]      wstrb;
    } cache_req_t;

    // Response handed from execute to the result stage
    typedef struct packed {
        logic                  is_write;
        logic [DATA_WIDTH-1:0] rdata;
        logic [1:0]            resp;
        logic                  hit;
    } cache_rsp_t;

    // Replaces the strobed bytes of a stored word with the new ones
    function automatic logic [DATA_WIDTH-1:0] byte_merge(
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] new_word,
        input logic [STRB_WIDTH-1:0] strb
    );
        logic [DATA_WIDTH-1:0] merged;
        merged = old_word;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: source/dcache_hit_check.sv
`timescale 1ns/1ps

module dcache_hit_check (
    input  logic                                                          hit_o,
    input  logic [dcache_pkg::WAYS_NUMBER-1:0][dcache_pkg::TAG_SIZE-1:0] cache_tag_i,
    input  logic [dcache_pkg::WAYS_NUMBER-1:0]                           cache_valid_i,
    input  logic [dcache_pkg::TAG_SIZE-1:0]                              address_tag_i,
    output logic                                                          hit_flag_o,
    output logic [dcache_pkg::WAYS_NUMBER-1:0]                           way_hit_o
);

    logic [dcache_pkg::WAYS_NUMBER-1:0] way_hit;

    // A way hits when it holds a valid line with the requested tag
    always_comb begin
        way_hit = '0;
        for (int w = 0; w < dcache_pkg::WAYS_NUMBER; w++) begin
            way_hit[w] = (cache_tag_i[w] == address_tag_i) && cache_valid_i[w];
        end
    end

    assign hit_flag_o = |way_hit;
    assign way_hit_o  = way_hit;

    // Refill only targets a set on a miss, so one tag never sits in two ways
    a_way_hit_onehot: assert property (
        @(posedge hit_o) disable iff ($isunknown(cache_valid_i))
        $onehot0(way_hit_o)
    ) else $error("more than one way hit for tag %0h", address_tag_i);

endmodule

// File: source/dcache_req_decode.sv
`timescale 1ns/1ps

module dcache_req_decode (
    input  logic                              hit_o,
    input  logic                              rst_n_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] awaddr_i,
    input  logic                              awvalid_i,
    output logic                              awready_o,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [dcache_pkg::STRB_WIDTH-1:0] wstrb_i,
    input  logic                              wvalid_i,
    output logic                              wready_o,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] araddr_i,
    input  logic                              arvalid_i,
    output logic                              arready_o,
    output dcache_pkg::cache_req_t            req_o,
    output logic                              req_valid_o,
    input  logic                              req_done_i
);

    // High from the issuing edge until execute reports the response taken
    logic busy_q;

    // AW and W may arrive in either order, each one is parked here
    logic                              aw_seen_q;
    logic                              w_seen_q;
    logic [dcache_pkg::ADDR_WIDTH-1:0] aw_addr_q;
    logic [dcache_pkg::DATA_WIDTH-1:0] w_data_q;
    logic [dcache_pkg::STRB_WIDTH-1:0] w_strb_q;

    logic                              aw_ok;
    logic                              w_ok;
    logic                              read_go;
    logic                              write_go;
    logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr;
    logic [dcache_pkg::DATA_WIDTH-1:0] wr_data;
    logic [dcache_pkg::STRB_WIDTH-1:0] wr_strb;

    // ----------------------------------------
    // Handshakes and arbitration
    // ----------------------------------------

    // A channel is only ready while idle and while its holding slot is free
    assign arready_o = !busy_q;
    assign awready_o = !busy_q && !aw_seen_q;
    assign wready_o  = !busy_q && !w_seen_q;

    // Each half of a write is available either from its slot or from the bus
    assign aw_ok   = aw_seen_q || (awvalid_i && awready_o);
    assign w_ok    = w_seen_q || (wvalid_i && wready_o);
    assign wr_data = w_seen_q ? w_data_q : wdata_i;
    assign wr_strb = w_seen_q ? w_strb_q : wstrb_i;

    // A waiting read wins, a complete write goes only when no read is offered
    assign read_go  = arvalid_i && arready_o;
    assign write_go = !busy_q && !arvalid_i && aw_ok && w_ok;

    always_comb begin
        if (read_go) begin
            req_addr = araddr_i;
        end else begin
            req_addr = aw_seen_q ? aw_addr_q : awaddr_i;
        end
    end

    always_ff @(posedge hit_o) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            aw_seen_q   <= 1'b0;
            w_seen_q    <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            // Slots stay filled until the write they belong to is issued
            aw_seen_q   <= aw_ok && !write_go;
            w_seen_q    <= w_ok && !write_go;
            req_valid_o <= read_go || write_go;
            if (read_go || write_go) begin
                busy_q <= 1'b1;
            end else if (req_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Address split and request register
    // ----------------------------------------

    always_ff @(posedge hit_o) begin
        if (awvalid_i && awready_o) begin
            aw_addr_q <= awaddr_i;
        end
        if (wvalid_i && wready_o) begin
            w_data_q <= wdata_i;
            w_strb_q <= wstrb_i;
        end
        if (read_go || write_go) begin
            req_o.is_write     <= write_go;
            req_o.out_of_range <= req_addr >= dcache_pkg::WINDOW_LIMIT;
            req_o.tag          <= req_addr[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_SIZE];
            req_o.index        <= req_addr[dcache_pkg::INDEX_LSB +: dcache_pkg::INDEX_SIZE];
            req_o.word_addr    <= req_addr[dcache_pkg::INDEX_LSB +: dcache_pkg::STORE_ADDR_SIZE];
            req_o.wdata        <= wr_data;
            req_o.wstrb        <= wr_strb;
        end
    end

    // Only one request may be in flight through the execute stage
    a_one_in_flight: assert property (
        @(posedge hit_o) disable iff (!rst_n_i)
        req_valid_o |=> (!req_valid_o until_with req_done_i)
    ) else $error("req_valid_o rose again before req_done_i");

endmodule

// File: source/dcache_way_array.sv
`timescale 1ns/1ps

module dcache_way_array (
    input  logic                                   hit_o,
    input  logic                                   rst_n_i,
    input  dcache_pkg::cache_req_t                 req_i,
    input  logic                                   req_valid_i,
    output logic                                   req_done_o,
    output logic [dcache_pkg::STORE_ADDR_SIZE-1:0] store_raddr_o,
    output logic                                   store_we_o,
    output logic [dcache_pkg::STORE_ADDR_SIZE-1:0] store_waddr_o,
    output logic [dcache_pkg::DATA_WIDTH-1:0]      store_wdata_o,
    output logic [dcache_pkg::STRB_WIDTH-1:0]      store_wstrb_o,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]      store_rdata_i,
    output dcache_pkg::cache_rsp_t                 rsp_o,
    output logic                                   rsp_valid_o,
    input  logic                                   resp_busy_i
);

    // Idle doubles as the lookup cycle, drain waits for the response handshake
    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,
        S_REFILL,
        S_RESP,
        S_DRAIN
    } state_t;

    state_t state_q;

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    logic [dcache_pkg::WAYS_NUMBER-1:0][dcache_pkg::TAG_SIZE-1:0]   tag_q [dcache_pkg::SETS_NUMBER];
    logic [dcache_pkg::WAYS_NUMBER-1:0][dcache_pkg::DATA_WIDTH-1:0] data_q [dcache_pkg::SETS_NUMBER];
    logic [dcache_pkg::SETS_NUMBER-1:0][dcache_pkg::WAYS_NUMBER-1:0] valid_q;

    // One bit per set naming the way to replace next
    logic [dcache_pkg::SETS_NUMBER-1:0] lru_q;

    logic [dcache_pkg::WAYS_NUMBER-1:0] way_hit;
    logic                               hit_flag;
    logic                               hit_way;
    logic                               fill_way;
    logic                               lookup;
    logic                               in_range_hit;
    dcache_pkg::cache_rsp_t             rsp_q;

    dcache_hit_check u_hit_check (
        .hit_o         (hit_o),
        .cache_tag_i   (tag_q[req_i.index]),
        .cache_valid_i (valid_q[req_i.index]),
        .address_tag_i (req_i.tag),
        .hit_flag_o    (hit_flag),
        .way_hit_o     (way_hit)
    );

    assign lookup       = (state_q == S_IDLE) && req_valid_i;
    assign in_range_hit = hit_flag && !req_i.out_of_range;
    // With two ways the upper hit bit is the way number
    assign hit_way      = way_hit[1];
    assign fill_way     = lru_q[req_i.index];

    // Every in-range write goes through to the store in the lookup cycle
    assign store_we_o    = lookup && req_i.is_write && !req_i.out_of_range;
    assign store_waddr_o = req_i.word_addr;
    assign store_wdata_o = req_i.wdata;
    assign store_wstrb_o = req_i.wstrb;
    // The read address is held, so refill sees the word written a cycle before
    assign store_raddr_o = req_i.word_addr;

    assign rsp_o       = rsp_q;
    assign rsp_valid_o = (state_q == S_RESP) && !resp_busy_i;
    assign req_done_o  = (state_q == S_DRAIN) && !resp_busy_i;

    // ----------------------------------------
    // Control, valid and LRU
    // ----------------------------------------

    always_ff @(posedge hit_o) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            valid_q <= '0;
            lru_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (lookup && req_i.out_of_range) begin
                        state_q <= S_RESP;
                    end else if (lookup && hit_flag) begin
                        lru_q[req_i.index] <= !hit_way;
                        state_q            <= S_RESP;
                    end else if (lookup) begin
                        state_q <= S_WAIT;
                    end
                end
                // Store read latency, the word is valid from the next cycle
                S_WAIT: state_q <= S_REFILL;
                S_REFILL: begin
                    valid_q[req_i.index][fill_way] <= 1'b1;
                    lru_q[req_i.index]             <= !fill_way;
                    state_q                        <= S_RESP;
                end
                S_RESP: begin
                    if (!resp_busy_i) begin
                        state_q <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    if (!resp_busy_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Tags, data and response payload
    // ----------------------------------------

    always_ff @(posedge hit_o) begin
        if (lookup) begin
            rsp_q.is_write <= req_i.is_write;
            rsp_q.rdata    <= '0;
            rsp_q.resp     <= req_i.out_of_range ? dcache_pkg::RESP_SLVERR
                                                 : dcache_pkg::RESP_OKAY;
            rsp_q.hit      <= in_range_hit;
            if (in_range_hit && req_i.is_write) begin
                data_q[req_i.index][hit_way] <= dcache_pkg::byte_merge(
                    data_q[req_i.index][hit_way], req_i.wdata, req_i.wstrb);
            end else if (in_range_hit) begin
                rsp_q.rdata <= data_q[req_i.index][hit_way];
            end
        end
        // Allocation takes the merged word from the store for reads and writes
        if (state_q == S_REFILL) begin
            tag_q[req_i.index][fill_way]  <= req_i.tag;
            data_q[req_i.index][fill_way] <= store_rdata_i;
            if (!req_i.is_write) begin
                rsp_q.rdata <= store_rdata_i;
            end
        end
    end

    // The word read back after a write must be the one that was just written
    a_store_same_addr: assert property (
        @(posedge hit_o) disable iff (!rst_n_i)
        store_we_o |=> (store_raddr_o == $past(store_waddr_o))
    ) else $error("store read after a write went to a different address");

endmodule

// File: source/dcache_backing_store.sv
`timescale 1ns/1ps

module dcache_backing_store (
    input  logic                                   hit_o,
    input  logic                                   rst_n_i,
    input  logic [dcache_pkg::STORE_ADDR_SIZE-1:0] raddr_i,
    input  logic                                   we_i,
    input  logic [dcache_pkg::STORE_ADDR_SIZE-1:0] waddr_i,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]      wdata_i,
    input  logic [dcache_pkg::STRB_WIDTH-1:0]      wstrb_i,
    output logic [dcache_pkg::DATA_WIDTH-1:0]      rdata_o
);

    logic [dcache_pkg::DATA_WIDTH-1:0] mem_q [dcache_pkg::STORE_DEPTH];

    // Main memory starts all zero, so unwritten words read back as zero
    always_ff @(posedge hit_o) begin
        if (!rst_n_i) begin
            for (int i = 0; i < dcache_pkg::STORE_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we_i) begin
            mem_q[waddr_i] <= dcache_pkg::byte_merge(mem_q[waddr_i], wdata_i, wstrb_i);
        end
    end

    // Registered read, a write to the same word shows up one cycle later
    always_ff @(posedge hit_o) begin
        rdata_o <= mem_q[raddr_i];
    end

endmodule

// File: source/dcache_resp_gen.sv
`timescale 1ns/1ps

module dcache_resp_gen (
    input  logic                              hit_o,
    input  logic                              rst_n_i,
    input  dcache_pkg::cache_rsp_t            rsp_i,
    input  logic                              rsp_valid_i,
    output logic [dcache_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic [1:0]                        rresp_o,
    output logic                              rvalid_o,
    input  logic                              rready_i,
    output logic [1:0]                        bresp_o,
    output logic                              bvalid_o,
    input  logic                              bready_i,
    output logic                              rsp_hit_o,
    output logic                              resp_busy_o
);

    dcache_pkg::cache_rsp_t rsp_q;
    logic                   rvalid_q;
    logic                   bvalid_q;

    // ----------------------------------------
    // Channel valids
    // ----------------------------------------

    // A new response goes to R or B and stays up until that channel's ready
    always_ff @(posedge hit_o) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (rsp_valid_i && !rsp_i.is_write) begin
                rvalid_q <= 1'b1;
            end else if (rready_i) begin
                rvalid_q <= 1'b0;
            end
            if (rsp_valid_i && rsp_i.is_write) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge hit_o) begin
        if (rsp_valid_i) begin
            rsp_q <= rsp_i;
        end
    end

    assign rvalid_o    = rvalid_q;
    assign bvalid_o    = bvalid_q;
    assign rdata_o     = rsp_q.rdata;
    assign rresp_o     = rsp_q.resp;
    assign bresp_o     = rsp_q.resp;
    assign resp_busy_o = rvalid_q || bvalid_q;
    // Hit flag is only meaningful beside a valid response
    assign rsp_hit_o   = rsp_q.hit && resp_busy_o;

    a_r_stable: assert property (
        @(posedge hit_o) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o)
    ) else $error("R channel changed while waiting for RREADY");

    a_b_stable: assert property (
        @(posedge hit_o) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o)
    ) else $error("B channel changed while waiting for BREADY");

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                              hit_o,
    input  logic                              rst_n_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] awaddr_i,
    input  logic                              awvalid_i,
    output logic                              awready_o,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [dcache_pkg::STRB_WIDTH-1:0] wstrb_i,
    input  logic                              wvalid_i,
    output logic                              wready_o,
    output logic [1:0]                        bresp_o,
    output logic                              bvalid_o,
    input  logic                              bready_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] araddr_i,
    input  logic                              arvalid_i,
    output logic                              arready_o,
    output logic [dcache_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic [1:0]                        rresp_o,
    output logic                              rvalid_o,
    input  logic                              rready_i,
    output logic                              rsp_hit_o
);

    // Decode to execute
    dcache_pkg::cache_req_t req;
    logic                   req_valid;
    logic                   req_done;

    // Execute to result
    dcache_pkg::cache_rsp_t rsp;
    logic                   rsp_valid;
    logic                   resp_busy;

    // Execute to backing store
    logic [dcache_pkg::STORE_ADDR_SIZE-1:0] store_raddr;
    logic                                   store_we;
    logic [dcache_pkg::STORE_ADDR_SIZE-1:0] store_waddr;
    logic [dcache_pkg::DATA_WIDTH-1:0]      store_wdata;
    logic [dcache_pkg::STRB_WIDTH-1:0]      store_wstrb;
    logic [dcache_pkg::DATA_WIDTH-1:0]      store_rdata;

    dcache_req_decode u_decode (
        .hit_o       (hit_o),
        .rst_n_i     (rst_n_i),
        .awaddr_i    (awaddr_i),
        .awvalid_i   (awvalid_i),
        .awready_o   (awready_o),
        .wdata_i     (wdata_i),
        .wstrb_i     (wstrb_i),
        .wvalid_i    (wvalid_i),
        .wready_o    (wready_o),
        .araddr_i    (araddr_i),
        .arvalid_i   (arvalid_i),
        .arready_o   (arready_o),
        .req_o       (req),
        .req_valid_o (req_valid),
        .req_done_i  (req_done)
    );

    dcache_way_array u_execute (
        .hit_o         (hit_o),
        .rst_n_i       (rst_n_i),
        .req_i         (req),
        .req_valid_i   (req_valid),
        .req_done_o    (req_done),
        .store_raddr_o (store_raddr),
        .store_we_o    (store_we),
        .store_waddr_o (store_waddr),
        .store_wdata_o (store_wdata),
        .store_wstrb_o (store_wstrb),
        .store_rdata_i (store_rdata),
        .rsp_o         (rsp),
        .rsp_valid_o   (rsp_valid),
        .resp_busy_i   (resp_busy)
    );

    dcache_backing_store u_store (
        .hit_o   (hit_o),
        .rst_n_i (rst_n_i),
        .raddr_i (store_raddr),
        .we_i    (store_we),
        .waddr_i (store_waddr),
        .wdata_i (store_wdata),
        .wstrb_i (store_wstrb),
        .rdata_o (store_rdata)
    );

    dcache_resp_gen u_result (
        .hit_o       (hit_o),
        .rst_n_i     (rst_n_i),
        .rsp_i       (rsp),
        .rsp_valid_i (rsp_valid),
        .rdata_o     (rdata_o),
        .rresp_o     (rresp_o),
        .rvalid_o    (rvalid_o),
        .rready_i    (rready_i),
        .bresp_o     (bresp_o),
        .bvalid_o    (bvalid_o),
        .bready_i    (bready_i),
        .rsp_hit_o   (rsp_hit_o),
        .resp_busy_o (resp_busy)
    );

endmodule

// File: tb/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int WAIT_LIMIT = 50;
    localparam int RANDOM_OPS = 300;

    logic                              hit_o;
    logic                              rst_n_i;
    logic [dcache_pkg::ADDR_WIDTH-1:0] awaddr_i;
    logic                              awvalid_i;
    logic                              awready_o;
    logic [dcache_pkg::DATA_WIDTH-1:0] wdata_i;
    logic [dcache_pkg::STRB_WIDTH-1:0] wstrb_i;
    logic                              wvalid_i;
    logic                              wready_o;
    logic [1:0]                        bresp_o;
    logic                              bvalid_o;
    logic                              bready_i;
    logic [dcache_pkg::ADDR_WIDTH-1:0] araddr_i;
    logic                              arvalid_i;
    logic                              arready_o;
    logic [dcache_pkg::DATA_WIDTH-1:0] rdata_o;
    logic [1:0]                        rresp_o;
    logic                              rvalid_o;
    logic                              rready_i;
    logic                              rsp_hit_o;

    // Reference model: main memory plus per-set tags, valid bits and LRU
    logic [31:0] mem_m   [256];
    logic [3:0]  tag_m   [16][2];
    logic        valid_m [16][2];
    logic        lru_m   [16];

    // Prediction for the response that is currently outstanding
    logic        exp_write;
    logic [31:0] exp_rdata;
    logic [1:0]  exp_resp;
    logic        exp_hit;

    int          value_errors;
    int          protocol_errors;
    int          timeouts;
    logic [31:0] lcg_state;

    dcache_top UUT (.*);

    initial begin
        hit_o = 1'b0;
        forever #2 hit_o = ~hit_o;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Every byte lane with its strobe set takes the new byte
    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Applies one access to the model and records what the DUT must answer
    task automatic update_model(input bit is_write, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb);
        logic [3:0] idx;
        logic [3:0] tag;
        logic [7:0] word;
        int         way;
        exp_write = is_write;
        exp_hit   = 1'b0;
        if (addr >= dcache_pkg::WINDOW_LIMIT) begin
            exp_resp = dcache_pkg::RESP_SLVERR;
        end else begin
            idx      = addr[5:2];
            tag      = addr[9:6];
            word     = addr[9:2];
            exp_resp = dcache_pkg::RESP_OKAY;
            way      = -1;
            for (int w = 0; w < 2; w++) begin
                if (valid_m[idx][w] && tag_m[idx][w] == tag) begin
                    way = w;
                end
            end
            if (is_write) begin
                mem_m[word] = apply_strobes(mem_m[word], data, strb);
            end
            if (way >= 0) begin
                exp_hit = 1'b1;
            end else begin
                // Miss fills the way that the LRU bit names
                way               = lru_m[idx];
                tag_m[idx][way]   = tag;
                valid_m[idx][way] = 1'b1;
            end
            lru_m[idx] = (way == 0);
            exp_rdata  = mem_m[word];
        end
    endtask

    function automatic logic ready_or_valid(input int sel);
        case (sel)
            0:       return arready_o;
            1:       return awready_o && wready_o;
            2:       return rvalid_o;
            default: return bvalid_o;
        endcase
    endfunction

    // Outputs are looked at on the falling edge where they are settled
    task automatic wait_until_high(input int sel, input string what, output bit ok);
        int cycles;
        cycles = 0;
        @(negedge hit_o);
        while (!ready_or_valid(sel) && cycles < WAIT_LIMIT) begin
            @(negedge hit_o);
            cycles++;
        end
        ok = ready_or_valid(sel);
        if (!ok) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for %s", cycles, what);
        end
    endtask

    // One full transaction, with the response held off for hold cycles
    task automatic run_access(input bit is_write, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb,
                              input int hold);
        bit ok;
        if (timeouts != 0) begin
            return;
        end
        update_model(is_write, addr, data, strb);
        @(posedge hit_o);
        if (is_write) begin
            awaddr_i  <= addr;
            awvalid_i <= 1'b1;
            wdata_i   <= data;
            wstrb_i   <= strb;
            wvalid_i  <= 1'b1;
        end else begin
            araddr_i  <= addr;
            arvalid_i <= 1'b1;
        end
        wait_until_high(is_write ? 1 : 0, is_write ? "AWREADY and WREADY" : "ARREADY", ok);
        if (!ok) begin
            return;
        end
        @(posedge hit_o);
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        arvalid_i <= 1'b0;
        wait_until_high(is_write ? 3 : 2, is_write ? "BVALID" : "RVALID", ok);
        if (!ok) begin
            return;
        end
        @(posedge hit_o);
        repeat (hold) @(posedge hit_o);
        rready_i <= !is_write;
        bready_i <= is_write;
        @(posedge hit_o);
        rready_i <= 1'b0;
        bready_i <= 1'b0;
    endtask

    // ----------------------------------------
    // Checks at the response handshakes
    // ----------------------------------------

    a_rdata: assert property (@(posedge hit_o) disable iff (!rst_n_i)
        rvalid_o && rready_i && exp_resp == dcache_pkg::RESP_OKAY |-> rdata_o == exp_rdata)
    else begin
        value_errors++;
        $display("Error at %0t: rdata_o = %h, expected %h",
                 $time, $sampled(rdata_o), $sampled(exp_rdata));
    end

    a_rresp: assert property (@(posedge hit_o) disable iff (!rst_n_i)
        rvalid_o && rready_i |-> rresp_o == exp_resp)
    else begin
        value_errors++;
        $display("Error at %0t: rresp_o = %b, expected %b",
                 $time, $sampled(rresp_o), $sampled(exp_resp));
    end

    a_bresp: assert property (@(posedge hit_o) disable iff (!rst_n_i)
        bvalid_o && bready_i |-> bresp_o == exp_resp)
    else begin
        value_errors++;
        $display("Error at %0t: bresp_o = %b, expected %b",
                 $time, $sampled(bresp_o), $sampled(exp_resp));
    end

    a_hit: assert property (@(posedge hit_o) disable iff (!rst_n_i)
        (rvalid_o && rready_i) || (bvalid_o && bready_i) |-> rsp_hit_o == exp_hit)
    else begin
        value_errors++;
        $display("Error at %0t: rsp_hit_o = %b, expected %b",
                 $time, $sampled(rsp_hit_o), $sampled(exp_hit));
    end

    // A read must answer on R and a write on B
    a_channel: assert property (@(posedge hit_o) disable iff (!rst_n_i)
        (rvalid_o |-> !exp_write) and (bvalid_o |-> exp_write))
    else begin
        protocol_errors++;
        $display("Response at %0t came on the wrong channel", $time);
    end

    a_r_hold: assert property (@(posedge hit_o) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=>
            rvalid_o && $stable(rdata_o) && $stable(rresp_o) && $stable(rsp_hit_o))
    else begin
        protocol_errors++;
        $display("R response at %0t dropped or changed before RREADY", $time);
    end

    a_b_hold: assert property (@(posedge hit_o) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o) && $stable(rsp_hit_o))
    else begin
        protocol_errors++;
        $display("B response at %0t dropped or changed before BREADY", $time);
    end

    // No new request may be taken while a response is still pending
    a_blocked: assert property (@(posedge hit_o) disable iff (!rst_n_i)
        rvalid_o || bvalid_o |-> !arready_o && !awready_o && !wready_o)
    else begin
        protocol_errors++;
        $display("Request channel was ready at %0t while a response was pending", $time);
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        rst_n_i   <= 1'b0;
        awaddr_i  <= '0;
        awvalid_i <= 1'b0;
        wdata_i   <= '0;
        wstrb_i   <= '0;
        wvalid_i  <= 1'b0;
        bready_i  <= 1'b0;
        araddr_i  <= '0;
        arvalid_i <= 1'b0;
        rready_i  <= 1'b0;
        lcg_state       = 32'hfae0a403;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        exp_write       = 1'b0;
        exp_rdata       = '0;
        exp_resp        = dcache_pkg::RESP_OKAY;
        exp_hit         = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem_m[i] = '0;
        end
        for (int s = 0; s < 16; s++) begin
            lru_m[s]      = 1'b0;
            valid_m[s][0] = 1'b0;
            valid_m[s][1] = 1'b0;
        end
        repeat (3) @(posedge hit_o);
        rst_n_i <= 1'b1;

        // First touch misses, partial write then hit on the merged word
        run_access(1'b0, 32'h000, '0, '0, 0);
        run_access(1'b1, 32'h004, 32'ha5a5_1234, 4'b0011, 1);
        run_access(1'b0, 32'h004, '0, '0, 2);
        run_access(1'b1, 32'h004, 32'h77ee_9900, 4'b1100, 0);
        run_access(1'b0, 32'h004, '0, '0, 3);

        // Tags 1, 2 and 3 in set 3, so the first one gets evicted
        run_access(1'b0, 32'h04c, '0, '0, 0);
        run_access(1'b0, 32'h08c, '0, '0, 0);
        run_access(1'b0, 32'h0cc, '0, '0, 0);
        run_access(1'b0, 32'h04c, '0, '0, 1);
        run_access(1'b0, 32'h0cc, '0, '0, 1);

        // Out of range, the alias of word 0 must stay untouched
        run_access(1'b1, 32'h400, 32'hdead_beef, 4'b1111, 2);
        run_access(1'b0, 32'h400, '0, '0, 0);
        run_access(1'b0, 32'hffff_fffc, '0, '0, 1);
        run_access(1'b0, 32'h000, '0, '0, 0);

        // Random mix over four tags per set so hits and evictions both occur
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = next_rand();
            if (r[19:16] == 4'd0) begin
                addr = 32'h400 + {22'd0, r[27:20], 2'b00};
            end else begin
                addr = {22'd0, 2'b00, r[11:10], r[15:12], 2'b00};
            end
            // The top bit picks read or write, low LCG bits repeat too quickly
            run_access(r[31], addr, next_rand(), r[23:20], int'(r[25:24]));
        end

        repeat (4) @(posedge hit_o);
        $display("Value errors: %0d, protocol errors: %0d, timeouts: %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dcache_top.f
source/dcache_pkg.sv
source/dcache_hit_check.sv
source/dcache_req_decode.sv
source/dcache_way_array.sv
source/dcache_backing_store.sv
source/dcache_resp_gen.sv
source/dcache_top.sv
tb/dcache_tb.sv
